// File: build.f
gt_reset_pkg.sv
qpll_reset_seq.sv
gt_tx_reset_seq.sv
gt_rx_reset_seq.sv
gt_reset_ctrl.sv
tb_gt_reset_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the reset controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f build.f --top-module tb_gt_reset_ctrl \
    --Mdir obj_dir -o sim_gt_reset_ctrl > build.log 2>&1 \
    && ./obj_dir/sim_gt_reset_ctrl > sim.log 2>&1
grep -qsx "Testbench passed" sim.log \
    && echo "PASS" \
    || { echo "FAIL, see build.log and sim.log"; exit 1; }

// File: tb_gt_reset_ctrl.sv
// Testbench for the transceiver reset controller with GT model, reference model and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_gt_reset_ctrl;

localparam int CLK_PERIOD_NS = 4;
localparam int N_SEQ = 40;
// One full attempt, PLL relock through CDR timeout and user reset release
localparam int ATTEMPT_CYCLES = gt_reset_pkg::QPLL_RESET_CYCLES + 8
    + gt_reset_pkg::GT_RESET_CYCLES + 16 + gt_reset_pkg::CDR_TIMEOUT_CYCLES + 16
    + gt_reset_pkg::RST_STRETCH_CYCLES;
localparam int RETRY_FACTOR = 16;

logic clk = 1'b0;
logic arst_n;
logic gt_qpll_lock;
logic gt_qpll_reset;
gt_reset_pkg::gt_chan_ctrl_t gt_tx_ctrl;
gt_reset_pkg::gt_chan_ctrl_t gt_rx_ctrl;
gt_reset_pkg::gt_chan_stat_t gt_tx_stat;
gt_reset_pkg::gt_chan_stat_t gt_rx_stat;
logic tx_rst_in;
logic rx_rst_in;
logic tx_reset_done;
logic rx_reset_done;
logic tx_rst_out;
logic rx_rst_out;

// GT model
logic [15:0] lfsr;
int pll_wait;
gt_reset_pkg::gt_chan_stat_t chan_stat [2];
int up_cnt [2];
int clk_dly [2];
int done_dly [2];
int cdr_dly [2];
logic cdr_withheld [2];

// Reference model, index 0 is transmit and 1 is receive
gt_reset_pkg::qpll_state_e q_st;
int q_cnt;
logic q_rst;
logic q_locked;
gt_reset_pkg::chan_state_e m_st [2];
int m_cnt [2];
int m_cdr [2];
int m_hold [2];
logic m_gtrst [2];
logic m_rdy [2];
logic m_done [2];
int done_cnt [2];
int cdr_timeouts;
int pll_drops;

gt_reset_ctrl u_gt_reset_ctrl (
    .xcvr_ctrl_clk(clk),
    .arst_n(arst_n),
    .gt_qpll_reset(gt_qpll_reset),
    .gt_qpll_lock(gt_qpll_lock),
    .gt_tx_ctrl(gt_tx_ctrl),
    .gt_tx_stat(gt_tx_stat),
    .gt_rx_ctrl(gt_rx_ctrl),
    .gt_rx_stat(gt_rx_stat),
    .tx_rst_in(tx_rst_in),
    .rx_rst_in(rx_rst_in),
    .tx_reset_done(tx_reset_done),
    .rx_reset_done(rx_reset_done),
    .tx_rst_out(tx_rst_out),
    .rx_rst_out(rx_rst_out)
);

always #(CLK_PERIOD_NS / 2) clk = ~clk;

// x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

function automatic int rand_bits(input int n);
    int r;
    r = 0;
    for (int i = 0; i < n; i++) begin
        lfsr = lfsr_next(lfsr);
        r = (r << 1) | int'(lfsr[0]);
    end
    return r;
endfunction

task automatic compare_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
        $display("Mismatch at %0d ns: %s got %0h expected %0h", $time, what, got, exp);
        $display("Testbench failed");
        $fatal(1);
    end
endtask

function automatic gt_reset_pkg::gt_chan_ctrl_t expected_ctrl(input int ch);
    gt_reset_pkg::gt_chan_ctrl_t c;
    c.gt_reset = m_gtrst[ch];
    c.prgdiv_reset = m_gtrst[ch];
    c.userrdy = m_rdy[ch];
    return c;
endfunction

task automatic reset_model();
    q_st = gt_reset_pkg::QPLL_RESET;
    q_cnt = 0;
    q_rst = 1'b1;
    q_locked = 1'b0;
    for (int ch = 0; ch < 2; ch++) begin
        m_st[ch] = gt_reset_pkg::CH_WAIT_PLL;
        m_hold[ch] = 0;
        m_gtrst[ch] = 1'b1;
        m_rdy[ch] = 1'b0;
        m_done[ch] = 1'b0;
    end
endtask

task automatic step_chan(input int ch, input logic pll_ok, input logic rst_req,
                         input gt_reset_pkg::gt_chan_stat_t st);
    logic was_done;
    was_done = m_done[ch];
    // Release counts edges with done high and no request
    if (!m_done[ch] || rst_req) begin
        m_hold[ch] = 0;
    end else if (m_hold[ch] < gt_reset_pkg::RST_STRETCH_CYCLES) begin
        m_hold[ch]++;
    end
    if (m_st[ch] != gt_reset_pkg::CH_WAIT_PLL && (!pll_ok || rst_req)) begin
        m_st[ch] = pll_ok ? gt_reset_pkg::CH_RESET : gt_reset_pkg::CH_WAIT_PLL;
        m_cnt[ch] = 0;
        m_gtrst[ch] = 1'b1;
        m_rdy[ch] = 1'b0;
        m_done[ch] = 1'b0;
    end else begin
        case (m_st[ch])
            gt_reset_pkg::CH_WAIT_PLL: begin
                if (pll_ok) begin
                    m_st[ch] = gt_reset_pkg::CH_RESET;
                    m_cnt[ch] = 0;
                end
            end
            gt_reset_pkg::CH_RESET: begin
                m_cnt[ch]++;
                if (m_cnt[ch] == gt_reset_pkg::GT_RESET_CYCLES) begin
                    m_st[ch] = gt_reset_pkg::CH_WAIT_CLK;
                    m_gtrst[ch] = 1'b0;
                end
            end
            gt_reset_pkg::CH_WAIT_CLK: begin
                if (st.prgdiv_reset_done && st.userclk_active) begin
                    m_st[ch] = gt_reset_pkg::CH_WAIT_DONE;
                    m_rdy[ch] = 1'b1;
                end
            end
            gt_reset_pkg::CH_WAIT_DONE: begin
                if (st.reset_done && ch == 1) begin
                    m_st[ch] = gt_reset_pkg::CH_WAIT_CDR;
                    m_cdr[ch] = 0;
                end else if (st.reset_done) begin
                    m_st[ch] = gt_reset_pkg::CH_DONE;
                    m_done[ch] = 1'b1;
                end
            end
            gt_reset_pkg::CH_WAIT_CDR: begin
                m_cdr[ch]++;
                if (st.cdr_lock) begin
                    m_st[ch] = gt_reset_pkg::CH_DONE;
                    m_done[ch] = 1'b1;
                end else if (m_cdr[ch] == gt_reset_pkg::CDR_TIMEOUT_CYCLES) begin
                    m_st[ch] = gt_reset_pkg::CH_RESET;
                    m_cnt[ch] = 0;
                    m_gtrst[ch] = 1'b1;
                    m_rdy[ch] = 1'b0;
                    cdr_timeouts++;
                end
            end
            default: begin
            end
        endcase
    end
    if (!was_done && m_done[ch]) begin
        done_cnt[ch]++;
    end
endtask

task automatic step_qpll();
    case (q_st)
        gt_reset_pkg::QPLL_RESET: begin
            q_cnt++;
            if (q_cnt == gt_reset_pkg::QPLL_RESET_CYCLES) begin
                q_st = gt_reset_pkg::QPLL_WAIT_LOCK;
                q_rst = 1'b0;
            end
        end
        gt_reset_pkg::QPLL_WAIT_LOCK: begin
            if (gt_qpll_lock) begin
                q_st = gt_reset_pkg::QPLL_LOCKED;
                q_locked = 1'b1;
            end
        end
        default: begin
            if (!gt_qpll_lock) begin
                q_st = gt_reset_pkg::QPLL_RESET;
                q_cnt = 0;
                q_rst = 1'b1;
                q_locked = 1'b0;
                pll_drops++;
            end
        end
    endcase
endtask

// Status comes up in order once the GT reset is released
task automatic drive_chan(input int ch, input gt_reset_pkg::gt_chan_ctrl_t ctrl);
    if (ctrl.gt_reset) begin
        chan_stat[ch] = '0;
        chan_stat[ch].cdr_lock = (ch == 0);
        up_cnt[ch] = 0;
    end else begin
        if (up_cnt[ch] == 0) begin
            clk_dly[ch] = 1 + rand_bits(3);
            done_dly[ch] = clk_dly[ch] + 1 + rand_bits(3);
            if (ch == 1) begin
                cdr_dly[ch] = done_dly[ch] + 1 + rand_bits(4);
                cdr_withheld[ch] = (rand_bits(2) == 0);
            end
        end
        up_cnt[ch]++;
        if (up_cnt[ch] >= clk_dly[ch]) begin
            chan_stat[ch].prgdiv_reset_done = 1'b1;
            chan_stat[ch].userclk_active = 1'b1;
        end
        if (up_cnt[ch] >= done_dly[ch]) begin
            chan_stat[ch].reset_done = 1'b1;
        end
        if (ch == 1 && !cdr_withheld[ch] && up_cnt[ch] >= cdr_dly[ch]) begin
            chan_stat[ch].cdr_lock = 1'b1;
        end
    end
endtask

task automatic drive_xcvr();
    if (gt_qpll_reset) begin
        gt_qpll_lock = 1'b0;
        pll_wait = -1;
    end else if (!gt_qpll_lock) begin
        if (pll_wait < 0) begin
            pll_wait = rand_bits(3);
        end
        if (pll_wait == 0) begin
            gt_qpll_lock = 1'b1;
        end else begin
            pll_wait--;
        end
    end else if (tx_reset_done && rx_reset_done) begin
        // Lock drop once both channels are up, held low until the PLL reset
        if (rand_bits(4) == 0) begin
            gt_qpll_lock = 1'b0;
            pll_wait = 1000;
        end
    end
    drive_chan(0, gt_tx_ctrl);
    drive_chan(1, gt_rx_ctrl);
    gt_tx_stat = chan_stat[0];
    gt_rx_stat = chan_stat[1];
    tx_rst_in = (rand_bits(7) == 0);
    rx_rst_in = (rand_bits(7) == 0);
endtask

always @(posedge clk) begin
    if (!arst_n) begin
        reset_model();
    end else begin
        // Channels see the PLL lock from before this edge
        step_chan(0, q_locked, tx_rst_in, gt_tx_stat);
        step_chan(1, q_locked, rx_rst_in, gt_rx_stat);
        step_qpll();
    end
end

always @(negedge clk) begin
    compare_value(32'(gt_qpll_reset), 32'(q_rst), "gt_qpll_reset");
    compare_value(32'(gt_tx_ctrl), 32'(expected_ctrl(0)), "gt_tx_ctrl");
    compare_value(32'(gt_rx_ctrl), 32'(expected_ctrl(1)), "gt_rx_ctrl");
    compare_value(32'(tx_reset_done), 32'(m_done[0]), "tx_reset_done");
    compare_value(32'(rx_reset_done), 32'(m_done[1]), "rx_reset_done");
    compare_value(32'(tx_rst_out),
                  32'(m_hold[0] < gt_reset_pkg::RST_STRETCH_CYCLES), "tx_rst_out");
    compare_value(32'(rx_rst_out),
                  32'(m_hold[1] < gt_reset_pkg::RST_STRETCH_CYCLES), "rx_rst_out");
end

initial begin
    #(N_SEQ * ATTEMPT_CYCLES * RETRY_FACTOR * CLK_PERIOD_NS);
    $display("Timeout: receive channel did not complete %0d sequences in time", N_SEQ);
    $display("Testbench failed");
    $fatal(1);
end

initial begin
    arst_n = 1'b0;
    gt_qpll_lock = 1'b0;
    tx_rst_in = 1'b0;
    rx_rst_in = 1'b0;
    lfsr = 16'd58;
    pll_wait = -1;
    cdr_timeouts = 0;
    pll_drops = 0;
    for (int ch = 0; ch < 2; ch++) begin
        chan_stat[ch] = '0;
        chan_stat[ch].cdr_lock = (ch == 0);
        up_cnt[ch] = 0;
        cdr_withheld[ch] = 1'b0;
        done_cnt[ch] = 0;
    end
    gt_tx_stat = chan_stat[0];
    gt_rx_stat = chan_stat[1];
    repeat (16) @(posedge clk);
    #1 arst_n = 1'b1;
    while (done_cnt[1] < N_SEQ) begin
        @(posedge clk);
        #1;
        drive_xcvr();
    end
    repeat (8) @(posedge clk);
    if (done_cnt[0] == 0 || cdr_timeouts == 0 || pll_drops == 0) begin
        $display("Run ended without a transmit completion, a CDR timeout or a PLL lock drop");
        $display("Testbench failed");
        $fatal(1);
    end else begin
        $display("Testbench passed");
        $finish;
    end
end

endmodule

`default_nettype wire

// File: gt_reset_ctrl.sv
// Transceiver reset controller top level with PLL and channel sequencers
`timescale 1ns/1ps
`default_nettype none

module gt_reset_ctrl (
    input  wire logic                        xcvr_ctrl_clk,
    input  wire logic                        arst_n,

    // Quad PLL
    output wire logic                        gt_qpll_reset,
    input  wire logic                        gt_qpll_lock,

    // GT channel
    output wire gt_reset_pkg::gt_chan_ctrl_t gt_tx_ctrl,
    input  wire gt_reset_pkg::gt_chan_stat_t gt_tx_stat,
    output wire gt_reset_pkg::gt_chan_ctrl_t gt_rx_ctrl,
    input  wire gt_reset_pkg::gt_chan_stat_t gt_rx_stat,

    // User side
    input  wire logic                        tx_rst_in,
    input  wire logic                        rx_rst_in,
    output wire logic                        tx_reset_done,
    output wire logic                        rx_reset_done,
    output wire logic                        tx_rst_out,
    output wire logic                        rx_rst_out
);

wire logic qpll_locked;

qpll_reset_seq u_qpll_reset_seq (
    .xcvr_ctrl_clk(xcvr_ctrl_clk),
    .arst_n(arst_n),
    .gt_qpll_lock(gt_qpll_lock),
    .gt_qpll_reset(gt_qpll_reset),
    .qpll_locked(qpll_locked)
);

gt_tx_reset_seq u_gt_tx_reset_seq (
    .xcvr_ctrl_clk(xcvr_ctrl_clk),
    .arst_n(arst_n),
    .qpll_locked(qpll_locked),
    .rst_in(tx_rst_in),
    .gt_stat(gt_tx_stat),
    .gt_ctrl(gt_tx_ctrl),
    .reset_done(tx_reset_done),
    .rst_out(tx_rst_out)
);

gt_rx_reset_seq u_gt_rx_reset_seq (
    .xcvr_ctrl_clk(xcvr_ctrl_clk),
    .arst_n(arst_n),
    .qpll_locked(qpll_locked),
    .rst_in(rx_rst_in),
    .gt_stat(gt_rx_stat),
    .gt_ctrl(gt_rx_ctrl),
    .reset_done(rx_reset_done),
    .rst_out(rx_rst_out)
);

endmodule

`default_nettype wire

// File: gt_rx_reset_seq.sv
// Receive channel reset state machine with CDR lock timeout and user reset stretcher
`timescale 1ns/1ps
`default_nettype none

module gt_rx_reset_seq (
    input  wire logic                       xcvr_ctrl_clk,
    input  wire logic                       arst_n,

    input  wire logic                       qpll_locked,
    input  wire logic                       rst_in,

    input  wire gt_reset_pkg::gt_chan_stat_t gt_stat,
    output gt_reset_pkg::gt_chan_ctrl_t      gt_ctrl,

    output logic                            reset_done,
    output logic                            rst_out
);

gt_reset_pkg::chan_state_e state;

logic [gt_reset_pkg::CNT_W-1:0] cnt;
logic [gt_reset_pkg::CNT_W-1:0] cdr_cnt;
logic [gt_reset_pkg::RST_STRETCH_CYCLES-1:0] rst_sr;

always_ff @(posedge xcvr_ctrl_clk or negedge arst_n) begin
    if (!arst_n) begin
        state <= gt_reset_pkg::CH_WAIT_PLL;
        cnt <= '0;
        cdr_cnt <= '0;
        gt_ctrl <= '{gt_reset: 1'b1, prgdiv_reset: 1'b1, userrdy: 1'b0};
        reset_done <= 1'b0;
    end else if (state != gt_reset_pkg::CH_WAIT_PLL && !qpll_locked) begin
        // PLL dropped out, park until it relocks
        state <= gt_reset_pkg::CH_WAIT_PLL;
        gt_ctrl <= '{gt_reset: 1'b1, prgdiv_reset: 1'b1, userrdy: 1'b0};
        reset_done <= 1'b0;
    end else if (state != gt_reset_pkg::CH_WAIT_PLL && rst_in) begin
        state <= gt_reset_pkg::CH_RESET;
        cnt <= '0;
        gt_ctrl <= '{gt_reset: 1'b1, prgdiv_reset: 1'b1, userrdy: 1'b0};
        reset_done <= 1'b0;
    end else begin
        case (state)
            gt_reset_pkg::CH_WAIT_PLL: begin
                if (qpll_locked) begin
                    state <= gt_reset_pkg::CH_RESET;
                    cnt <= '0;
                end
            end
            gt_reset_pkg::CH_RESET: begin
                cnt <= cnt + 1'b1;
                if (int'(cnt) == gt_reset_pkg::GT_RESET_CYCLES - 1) begin
                    state <= gt_reset_pkg::CH_WAIT_CLK;
                    gt_ctrl.gt_reset <= 1'b0;
                    gt_ctrl.prgdiv_reset <= 1'b0;
                end
            end
            gt_reset_pkg::CH_WAIT_CLK: begin
                if (gt_stat.prgdiv_reset_done && gt_stat.userclk_active) begin
                    state <= gt_reset_pkg::CH_WAIT_DONE;
                    gt_ctrl.userrdy <= 1'b1;
                end
            end
            gt_reset_pkg::CH_WAIT_DONE: begin
                if (gt_stat.reset_done) begin
                    state <= gt_reset_pkg::CH_WAIT_CDR;
                    cdr_cnt <= '0;
                end
            end
            gt_reset_pkg::CH_WAIT_CDR: begin
                cdr_cnt <= cdr_cnt + 1'b1;
                if (gt_stat.cdr_lock) begin
                    state <= gt_reset_pkg::CH_DONE;
                    reset_done <= 1'b1;
                end else if (int'(cdr_cnt) == gt_reset_pkg::CDR_TIMEOUT_CYCLES - 1) begin
                    // No CDR lock in time, rerun the GT reset pulse
                    state <= gt_reset_pkg::CH_RESET;
                    cnt <= '0;
                    gt_ctrl <= '{gt_reset: 1'b1, prgdiv_reset: 1'b1, userrdy: 1'b0};
                end
            end
            gt_reset_pkg::CH_DONE: begin
                state <= gt_reset_pkg::CH_DONE;
            end
            default: begin
                state <= gt_reset_pkg::CH_WAIT_PLL;
            end
        endcase
    end
end

// User reset release delayed behind reset done
always_ff @(posedge xcvr_ctrl_clk or negedge arst_n) begin
    if (!arst_n) begin
        rst_sr <= '1;
    end else if (!reset_done || rst_in) begin
        rst_sr <= '1;
    end else begin
        rst_sr <= rst_sr << 1;
    end
end

assign rst_out = rst_sr[gt_reset_pkg::RST_STRETCH_CYCLES-1];

// Done only ever follows a CDR lock seen while waiting for it
assert property (@(posedge xcvr_ctrl_clk) disable iff (!arst_n)
    $rose(reset_done) |-> $past(state == gt_reset_pkg::CH_WAIT_CDR && gt_stat.cdr_lock));

endmodule

`default_nettype wire

// File: gt_tx_reset_seq.sv
// Transmit channel reset state machine with user reset stretcher
`timescale 1ns/1ps
`default_nettype none

module gt_tx_reset_seq (
    input  wire logic                       xcvr_ctrl_clk,
    input  wire logic                       arst_n,

    input  wire logic                       qpll_locked,
    input  wire logic                       rst_in,

    input  wire gt_reset_pkg::gt_chan_stat_t gt_stat,
    output gt_reset_pkg::gt_chan_ctrl_t      gt_ctrl,

    output logic                            reset_done,
    output logic                            rst_out
);

gt_reset_pkg::chan_state_e state;

logic [gt_reset_pkg::CNT_W-1:0] cnt;
logic [gt_reset_pkg::RST_STRETCH_CYCLES-1:0] rst_sr;

always_ff @(posedge xcvr_ctrl_clk or negedge arst_n) begin
    if (!arst_n) begin
        state <= gt_reset_pkg::CH_WAIT_PLL;
        cnt <= '0;
        gt_ctrl <= '{gt_reset: 1'b1, prgdiv_reset: 1'b1, userrdy: 1'b0};
        reset_done <= 1'b0;
    end else if (state != gt_reset_pkg::CH_WAIT_PLL && !qpll_locked) begin
        // PLL dropped out, park until it relocks
        state <= gt_reset_pkg::CH_WAIT_PLL;
        gt_ctrl <= '{gt_reset: 1'b1, prgdiv_reset: 1'b1, userrdy: 1'b0};
        reset_done <= 1'b0;
    end else if (state != gt_reset_pkg::CH_WAIT_PLL && rst_in) begin
        state <= gt_reset_pkg::CH_RESET;
        cnt <= '0;
        gt_ctrl <= '{gt_reset: 1'b1, prgdiv_reset: 1'b1, userrdy: 1'b0};
        reset_done <= 1'b0;
    end else begin
        case (state)
            gt_reset_pkg::CH_WAIT_PLL: begin
                if (qpll_locked) begin
                    state <= gt_reset_pkg::CH_RESET;
                    cnt <= '0;
                end
            end
            gt_reset_pkg::CH_RESET: begin
                cnt <= cnt + 1'b1;
                if (int'(cnt) == gt_reset_pkg::GT_RESET_CYCLES - 1) begin
                    state <= gt_reset_pkg::CH_WAIT_CLK;
                    gt_ctrl.gt_reset <= 1'b0;
                    gt_ctrl.prgdiv_reset <= 1'b0;
                end
            end
            gt_reset_pkg::CH_WAIT_CLK: begin
                // Divider out of reset and user clock running
                if (gt_stat.prgdiv_reset_done && gt_stat.userclk_active) begin
                    state <= gt_reset_pkg::CH_WAIT_DONE;
                    gt_ctrl.userrdy <= 1'b1;
                end
            end
            gt_reset_pkg::CH_WAIT_DONE: begin
                if (gt_stat.reset_done) begin
                    state <= gt_reset_pkg::CH_DONE;
                    reset_done <= 1'b1;
                end
            end
            gt_reset_pkg::CH_DONE: begin
                state <= gt_reset_pkg::CH_DONE;
            end
            default: begin
                state <= gt_reset_pkg::CH_WAIT_PLL;
            end
        endcase
    end
end

// User reset release delayed behind reset done
always_ff @(posedge xcvr_ctrl_clk or negedge arst_n) begin
    if (!arst_n) begin
        rst_sr <= '1;
    end else if (!reset_done || rst_in) begin
        rst_sr <= '1;
    end else begin
        rst_sr <= rst_sr << 1;
    end
end

assign rst_out = rst_sr[gt_reset_pkg::RST_STRETCH_CYCLES-1];

assert property (@(posedge xcvr_ctrl_clk) disable iff (!arst_n)
    gt_ctrl.userrdy |-> !gt_ctrl.gt_reset);

assert property (@(posedge xcvr_ctrl_clk) disable iff (!arst_n)
    reset_done |-> gt_ctrl.userrdy);

endmodule

`default_nettype wire

// File: qpll_reset_seq.sv
// Quad PLL reset state machine with lock tracking
`timescale 1ns/1ps
`default_nettype none

module qpll_reset_seq (
    input  wire logic xcvr_ctrl_clk,
    input  wire logic arst_n,

    input  wire logic gt_qpll_lock,
    output logic      gt_qpll_reset,

    output logic      qpll_locked
);

gt_reset_pkg::qpll_state_e state;

logic [gt_reset_pkg::CNT_W-1:0] cnt;

always_ff @(posedge xcvr_ctrl_clk or negedge arst_n) begin
    if (!arst_n) begin
        state <= gt_reset_pkg::QPLL_RESET;
        cnt <= '0;
        gt_qpll_reset <= 1'b1;
        qpll_locked <= 1'b0;
    end else begin
        case (state)
            gt_reset_pkg::QPLL_RESET: begin
                // Hold the PLL in reset for the full count
                cnt <= cnt + 1'b1;
                if (int'(cnt) == gt_reset_pkg::QPLL_RESET_CYCLES - 1) begin
                    state <= gt_reset_pkg::QPLL_WAIT_LOCK;
                    gt_qpll_reset <= 1'b0;
                end
            end
            gt_reset_pkg::QPLL_WAIT_LOCK: begin
                if (gt_qpll_lock) begin
                    state <= gt_reset_pkg::QPLL_LOCKED;
                    qpll_locked <= 1'b1;
                end
            end
            gt_reset_pkg::QPLL_LOCKED: begin
                // Lock lost, start over
                if (!gt_qpll_lock) begin
                    state <= gt_reset_pkg::QPLL_RESET;
                    cnt <= '0;
                    gt_qpll_reset <= 1'b1;
                    qpll_locked <= 1'b0;
                end
            end
            default: begin
                state <= gt_reset_pkg::QPLL_RESET;
                cnt <= '0;
                gt_qpll_reset <= 1'b1;
                qpll_locked <= 1'b0;
            end
        endcase
    end
end

assert property (@(posedge xcvr_ctrl_clk) disable iff (!arst_n)
    !(qpll_locked && gt_qpll_reset));

endmodule

`default_nettype wire

// File: gt_reset_pkg.sv
// Timing constants, sequencer state enums and GT channel control and status structs
`default_nettype none

package gt_reset_pkg;

    // PLL reset hold time in control clock cycles
    localparam int QPLL_RESET_CYCLES = 16;

    // Channel GT reset pulse length
    localparam int GT_RESET_CYCLES = 16;

    // Receive side wait for CDR lock before the GT reset is rerun
    localparam int CDR_TIMEOUT_CYCLES = 64;

    // Delay from reset done to user reset release
    localparam int RST_STRETCH_CYCLES = 4;

    // Sequencer counter width
    localparam int CNT_W = 8;

    // Quad PLL sequencer states
    typedef enum logic [1:0] {
        QPLL_RESET,
        QPLL_WAIT_LOCK,
        QPLL_LOCKED
    } qpll_state_e;

    // Channel sequencer states, CH_WAIT_CDR is receive only
    typedef enum logic [2:0] {
        CH_WAIT_PLL,
        CH_RESET,
        CH_WAIT_CLK,
        CH_WAIT_DONE,
        CH_WAIT_CDR,
        CH_DONE
    } chan_state_e;

    // Sequencer to GT channel
    typedef struct packed {
        logic gt_reset;
        logic prgdiv_reset;
        logic userrdy;
    } gt_chan_ctrl_t;

    // GT channel to sequencer
    typedef struct packed {
        logic reset_done;
        logic prgdiv_reset_done;
        logic userclk_active;
        // Receive only, tied high on transmit
        logic cdr_lock;
    } gt_chan_stat_t;

endpackage

`default_nettype wire
